// ==== hdl/uart_pkg.sv ====
package uart_pkg;

	////////////////////////////////////////
	// Frame geometry

	// Raw 8N1 framing, no parity bit
	localparam int UART_DATA_BITS = 8;

	// Baud divisor width
	localparam int UART_DIV_BITS = 16;

	////////////////////////////////////////
	// Shared types

	// One data byte as carried on the wire
	typedef logic [UART_DATA_BITS-1:0] uart_byte_t;

	// Bit period is divisor + 1 clock cycles
	typedef logic [UART_DIV_BITS-1:0] uart_div_t;

	// Outcome of one received frame
	// frame_err set when the stop bit sampled low
	typedef struct packed {
		uart_byte_t data;
		logic       frame_err;
	} rx_beat_t;

endpackage

// ==== hdl/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx #(
	parameter bit SYNC_INIT = 1'b1
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                rx,
	input  uart_pkg::uart_div_t clkdiv,
	output logic                rx_active,
	output logic                rx_valid,
	output uart_pkg::rx_beat_t  rx_beat
);
	import uart_pkg::*;

	// One spare bit so 1.25x the largest divisor still fits
	localparam int CNT_W = UART_DIV_BITS + 1;

	////////////////////////////////////////
	// Input synchronizer

	logic [2:0] sync_q;
	logic       rx_sync;
	logic       rx_prev;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sync_q  <= {3{SYNC_INIT}};
			rx_prev <= SYNC_INIT;
		end else begin
			sync_q  <= {sync_q[1:0], rx};
			// Last synchronized level for start edge detection
			rx_prev <= rx_sync;
		end
	end

	assign rx_sync = sync_q[2];

	////////////////////////////////////////
	// Bit timing

	logic [CNT_W-1:0] baud_cnt;
	logic [CNT_W-1:0] start_dly;
	logic [3:0]       bit_cnt;
	logic             sample_now;
	logic             data_phase;
	uart_byte_t       shift_q;

	// Full period plus a quarter lands each sample a quarter into its bit
	assign start_dly = {1'b0, clkdiv} + CNT_W'(clkdiv[UART_DIV_BITS-1:2]);

	assign sample_now = rx_active && (baud_cnt == '0);
	// Still collecting data bits before the stop bit
	assign data_phase = bit_cnt < 4'(UART_DATA_BITS);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rx_active <= 1'b0;
			rx_valid  <= 1'b0;
			rx_beat   <= '0;
			baud_cnt  <= '0;
			bit_cnt   <= '0;
		end else begin
			// Strobe lasts a single cycle
			rx_valid <= 1'b0;
			if (!rx_active) begin
				// Only a falling edge starts a frame so a low stop bit cannot retrigger
				if (rx_prev && !rx_sync) begin
					rx_active <= 1'b1;
					baud_cnt  <= start_dly;
					bit_cnt   <= '0;
				end
			end else if (!sample_now) begin
				baud_cnt <= baud_cnt - CNT_W'(1);
			end else if (data_phase) begin
				bit_cnt  <= bit_cnt + 4'd1;
				baud_cnt <= {1'b0, clkdiv};
			end else begin
				// Stop sample hands the frame out and goes idle
				rx_active         <= 1'b0;
				rx_valid          <= 1'b1;
				rx_beat.data      <= shift_q;
				rx_beat.frame_err <= !rx_sync;
			end
		end
	end

	////////////////////////////////////////
	// Data shifter

	// LSB arrives first so bits shift in from the top
	always_ff @(posedge clk) begin
		if (sample_now && data_phase) begin
			shift_q <= {rx_sync, shift_q[UART_DATA_BITS-1:1]};
		end
	end

endmodule

// ==== hdl/uart_byte_fifo.sv ====
`timescale 1ns/1ps

module uart_byte_fifo #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 push,
	input  uart_pkg::uart_byte_t push_data,
	input  logic                 pop,
	output logic                 avail,
	output uart_pkg::uart_byte_t head,
	output logic                 overflow
);
	import uart_pkg::*;

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	uart_byte_t       mem [FIFO_DEPTH];
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;
	logic [CNT_W-1:0] count;
	logic             full;
	logic             do_push;
	logic             do_pop;

	// Explicit wrap keeps non power of two depths working
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
	endfunction

	assign full  = (count == CNT_W'(FIFO_DEPTH));
	assign avail = (count != '0);
	// Show-ahead head, valid whenever avail is high
	assign head  = mem[rd_ptr];

	assign do_pop  = pop && avail;
	// A pop in the same cycle frees the slot for the push
	assign do_push = push && (!full || do_pop);

	////////////////////////////////////////
	// Storage

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	////////////////////////////////////////
	// Pointers, occupancy, overflow

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_ptr   <= '0;
			wr_ptr   <= '0;
			count    <= '0;
			overflow <= 1'b0;
		end else begin
			if (do_push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			if (do_push && !do_pop) begin
				count <= count + CNT_W'(1);
			end else if (do_pop && !do_push) begin
				count <= count - CNT_W'(1);
			end
			// Sticky until reset once a byte is lost
			if (push && !do_push) begin
				overflow <= 1'b1;
			end
		end
	end

endmodule

// ==== hdl/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx (
	input  logic                 clk,
	input  logic                 rst_n,
	input  uart_pkg::uart_div_t  clkdiv,
	input  logic                 avail,
	input  uart_pkg::uart_byte_t head,
	output logic                 pop,
	output logic                 tx,
	output logic                 tx_busy,
	output logic                 tx_done
);
	import uart_pkg::*;

	uart_div_t  baud_cnt;
	logic [3:0] bit_cnt;
	logic       bit_end;
	logic       data_next;
	uart_byte_t shift_q;

	// Take the next byte as soon as the line is free
	assign pop = !tx_busy && avail;

	// Current bit has run its full period
	assign bit_end   = tx_busy && (baud_cnt == '0);
	// Bits 0 to 7 follow start and each data bit
	assign data_next = bit_cnt < 4'(UART_DATA_BITS);

	////////////////////////////////////////
	// Frame sequencer

	// bit_cnt 0 is the start bit, 9 the stop bit
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			tx       <= 1'b1;
			tx_busy  <= 1'b0;
			tx_done  <= 1'b0;
			baud_cnt <= '0;
			bit_cnt  <= '0;
		end else begin
			tx_done <= 1'b0;
			if (pop) begin
				// Start bit goes out right away
				tx       <= 1'b0;
				tx_busy  <= 1'b1;
				baud_cnt <= clkdiv;
				bit_cnt  <= '0;
			end else if (tx_busy) begin
				if (!bit_end) begin
					baud_cnt <= baud_cnt - UART_DIV_BITS'(1);
				end else if (data_next) begin
					tx       <= shift_q[0];
					bit_cnt  <= bit_cnt + 4'd1;
					baud_cnt <= clkdiv;
				end else if (bit_cnt == 4'(UART_DATA_BITS)) begin
					// Stop bit
					tx       <= 1'b1;
					bit_cnt  <= bit_cnt + 4'd1;
					baud_cnt <= clkdiv;
				end else begin
					// Stop bit period over
					tx_busy <= 1'b0;
					tx_done <= 1'b1;
				end
			end
		end
	end

	////////////////////////////////////////
	// Data shifter

	always_ff @(posedge clk) begin
		if (pop) begin
			shift_q <= head;
		end else if (bit_end && data_next) begin
			// LSB first, next bit moves into position 0
			shift_q <= {1'b0, shift_q[UART_DATA_BITS-1:1]};
		end
	end

endmodule

// ==== hdl/uart_echo_top.sv ====
`timescale 1ns/1ps

module uart_echo_top #(
	parameter int FIFO_DEPTH = 4,
	parameter bit SYNC_INIT  = 1'b1
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                rx,
	input  uart_pkg::uart_div_t rx_clkdiv,
	input  uart_pkg::uart_div_t tx_clkdiv,
	output logic                tx,
	output logic                rx_valid,
	output uart_pkg::rx_beat_t  rx_beat,
	output logic                overflow,
	output logic                tx_busy,
	output logic                tx_done
);
	import uart_pkg::*;

	logic       fifo_push;
	logic       fifo_pop;
	logic       fifo_avail;
	uart_byte_t fifo_head;

	////////////////////////////////////////
	// Receive side

	// rx_active has no consumer at this level
	uart_rx #(
		.SYNC_INIT (SYNC_INIT)
	) i_uart_rx (
		.clk       (clk),
		.rst_n     (rst_n),
		.rx        (rx),
		.clkdiv    (rx_clkdiv),
		.rx_active (),
		.rx_valid  (rx_valid),
		.rx_beat   (rx_beat)
	);

	// Bad frames are reported but never queued
	assign fifo_push = rx_valid && !rx_beat.frame_err;

	////////////////////////////////////////
	// Buffer and transmit side

	uart_byte_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) i_uart_byte_fifo (
		.clk       (clk),
		.rst_n     (rst_n),
		.push      (fifo_push),
		.push_data (rx_beat.data),
		.pop       (fifo_pop),
		.avail     (fifo_avail),
		.head      (fifo_head),
		.overflow  (overflow)
	);

	uart_tx i_uart_tx (
		.clk     (clk),
		.rst_n   (rst_n),
		.clkdiv  (tx_clkdiv),
		.avail   (fifo_avail),
		.head    (fifo_head),
		.pop     (fifo_pop),
		.tx      (tx),
		.tx_busy (tx_busy),
		.tx_done (tx_done)
	);

endmodule

// ==== include/uart_echo_cases.svh ====
`ifndef UART_ECHO_CASES_SVH
`define UART_ECHO_CASES_SVH

////////////////////////////////////////
// Echo stimulus table

// One row per burst of frames driven on rx
// rand_data picks payloads from $urandom instead of data
// n_echo is how many leading bytes of the burst come back on tx
typedef struct packed {
	uart_pkg::uart_byte_t data;
	logic                 rand_data;
	logic                 stop_bit;
	uart_pkg::uart_div_t  rx_div;
	uart_pkg::uart_div_t  tx_div;
	logic [3:0]           burst;
	logic [3:0]           n_echo;
	logic                 exp_frame_err;
	logic                 exp_overflow;
} echo_case_t;

localparam int ECHO_N_CASES = 6;

// Seed for random payloads
localparam int ECHO_SEED = 80;

// Overflow is sticky, so rows after the overflow burst expect it set
// data   rand  stop  rx_div  tx_div  burst echo  ferr  ovf
localparam echo_case_t ECHO_CASES [ECHO_N_CASES] = '{
	'{8'hA5, 1'b0, 1'b1, 16'd9,  16'd9,  4'd1, 4'd1, 1'b0, 1'b0},
	// Stop bit low, reported and not echoed
	'{8'h3C, 1'b0, 1'b0, 16'd9,  16'd9,  4'd1, 4'd0, 1'b1, 1'b0},
	'{8'h00, 1'b1, 1'b1, 16'd9,  16'd9,  4'd6, 4'd6, 1'b0, 1'b0},
	// Slow transmitter, bytes 5 to 7 fall on a full FIFO
	'{8'h00, 1'b1, 1'b1, 16'd4,  16'd49, 4'd8, 4'd5, 1'b0, 1'b1},
	'{8'h5A, 1'b0, 1'b1, 16'd9,  16'd30, 4'd1, 4'd1, 1'b0, 1'b1},
	'{8'h00, 1'b1, 1'b1, 16'd30, 16'd9,  4'd3, 4'd3, 1'b0, 1'b1}
};

`endif

// ==== verification/uart_echo_tb.sv ====
`timescale 1ns/1ps

module uart_echo_tb;
	import uart_pkg::*;

	`include "uart_echo_cases.svh"

	logic       clk;
	logic       rst_n;
	logic       rx;
	uart_div_t  rx_clkdiv;
	uart_div_t  tx_clkdiv;
	logic       tx;
	logic       rx_valid;
	rx_beat_t   rx_beat;
	logic       overflow;
	logic       tx_busy;
	logic       tx_done;

	// Current transmit bit period in cycles as used by the tx decoder
	int         p_tx;
	rx_beat_t   rx_got [$];
	uart_byte_t tx_got [$];

	uart_echo_top #(
		.FIFO_DEPTH (4)
	) i_uart_echo_top (
		.clk       (clk),
		.rst_n     (rst_n),
		.rx        (rx),
		.rx_clkdiv (rx_clkdiv),
		.tx_clkdiv (tx_clkdiv),
		.tx        (tx),
		.rx_valid  (rx_valid),
		.rx_beat   (rx_beat),
		.overflow  (overflow),
		.tx_busy   (tx_busy),
		.tx_done   (tx_done)
	);

	////////////////////////////////////////
	// Clock and watchdog

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Every frame bit at the slowest rate twice over plus slack
	function automatic int timeout_cycles();
		int bits;
		int p_max;
		bits  = 0;
		p_max = 0;
		for (int i = 0; i < ECHO_N_CASES; i++) begin
			bits += 10 * int'(ECHO_CASES[i].burst);
			if (int'(ECHO_CASES[i].rx_div) + 1 > p_max)
				p_max = int'(ECHO_CASES[i].rx_div) + 1;
			if (int'(ECHO_CASES[i].tx_div) + 1 > p_max)
				p_max = int'(ECHO_CASES[i].tx_div) + 1;
		end
		return bits * p_max * 2 + 1000;
	endfunction

	initial begin : watchdog
		int cycles;
		int limit;
		cycles = 0;
		limit  = timeout_cycles();
		while (cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("Echo timed out after %0d cycles", limit);
		$display("STATUS: FAIL");
		$fatal(1, "watchdog expired");
	end

	////////////////////////////////////////
	// Result checks

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("STATUS: FAIL");
		$fatal(1, "run aborted");
	endtask

	task automatic check_beat(input string name, input rx_beat_t got, input rx_beat_t exp);
		if (got !== exp) begin
			$display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
			$display("STATUS: FAIL");
			$fatal(1, "beat compare failed");
		end
	endtask

	task automatic check_byte(input string name, input uart_byte_t got, input uart_byte_t exp);
		if (got !== exp) begin
			$display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
			$display("STATUS: FAIL");
			$fatal(1, "byte compare failed");
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
			$display("STATUS: FAIL");
			$fatal(1, "flag compare failed");
		end
	endtask

	////////////////////////////////////////
	// Serial driver and monitors

	// Start bit, 8 data bits LSB first and stop bit held p cycles each
	task automatic send_frame(input uart_byte_t b, input logic stop, input int p);
		rx = 1'b0;
		repeat (p) @(negedge clk);
		for (int k = 0; k < UART_DATA_BITS; k++) begin
			rx = b[k];
			repeat (p) @(negedge clk);
		end
		rx = stop;
		repeat (p) @(negedge clk);
	endtask

	// One entry per rx_valid pulse
	initial begin : rx_watch
		forever begin
			@(negedge clk);
			if (rst_n && rx_valid)
				rx_got.push_back(rx_beat);
		end
	end

	// Tx decoder samples half a period past the start edge and then once per period
	// tx_done is due in the cycle right after the stop bit period
	initial begin : tx_watch
		uart_byte_t b;
		int         p;
		forever begin
			@(negedge clk);
			if (rst_n && tx === 1'b0) begin
				p = p_tx;
				repeat (p / 2) @(negedge clk);
				for (int k = 0; k < UART_DATA_BITS; k++) begin
					repeat (p) @(negedge clk);
					b[k] = tx;
				end
				repeat (p) @(negedge clk);
				if (tx !== 1'b1)
					abort_run("Stop bit on tx read low");
				else
					tx_got.push_back(b);
				repeat (p - p / 2) @(negedge clk);
				check_flag("tx_done", tx_done, 1'b1);
			end
		end
	end

	////////////////////////////////////////
	// Stimulus

	initial begin : stimulus
		echo_case_t c;
		uart_byte_t b;
		uart_byte_t sent [$];
		rx_beat_t   exp_beat;
		rst_n     = 1'b0;
		rx        = 1'b1;
		rx_clkdiv = ECHO_CASES[0].rx_div;
		tx_clkdiv = ECHO_CASES[0].tx_div;
		p_tx      = int'(ECHO_CASES[0].tx_div) + 1;
		void'($urandom(ECHO_SEED));
		repeat (3) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		// Idle line and clear flags out of reset
		check_flag("tx", tx, 1'b1);
		check_flag("overflow", overflow, 1'b0);
		check_flag("tx_busy", tx_busy, 1'b0);
		check_flag("rx_valid", rx_valid, 1'b0);
		check_flag("tx_done", tx_done, 1'b0);
		for (int r = 0; r < ECHO_N_CASES; r++) begin
			c         = ECHO_CASES[r];
			rx_clkdiv = c.rx_div;
			tx_clkdiv = c.tx_div;
			p_tx      = int'(c.tx_div) + 1;
			rx_got.delete();
			tx_got.delete();
			sent.delete();
			// Frames go out back to back
			for (int i = 0; i < int'(c.burst); i++) begin
				b = c.rand_data ? 8'($urandom) : c.data;
				sent.push_back(b);
				send_frame(b, c.stop_bit, int'(c.rx_div) + 1);
			end
			rx = 1'b1;
			while (rx_got.size() < int'(c.burst) || tx_got.size() < int'(c.n_echo))
				@(negedge clk);
			// Quiet window long enough for one more tx frame to show up
			repeat (12 * p_tx) @(negedge clk);
			if (rx_got.size() != int'(c.burst))
				abort_run("Receiver delivered more frames than were sent");
			if (tx_got.size() != int'(c.n_echo))
				abort_run("More bytes were echoed on tx than expected");
			for (int i = 0; i < int'(c.burst); i++) begin
				exp_beat.data      = sent[i];
				exp_beat.frame_err = c.exp_frame_err;
				check_beat("rx_beat", rx_got[i], exp_beat);
			end
			// Echo keeps the leading bytes in order
			for (int i = 0; i < int'(c.n_echo); i++)
				check_byte("tx_byte", tx_got[i], sent[i]);
			check_flag("overflow", overflow, c.exp_overflow);
			check_flag("tx_busy", tx_busy, 1'b0);
		end
		$display("STATUS: PASS");
		$finish;
	end

endmodule

// ==== filelist.f ====
+incdir+include
hdl/uart_pkg.sv
hdl/uart_rx.sv
hdl/uart_byte_fifo.sv
hdl/uart_tx.sv
hdl/uart_echo_top.sv
verification/uart_echo_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the echo testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module uart_echo_tb -f filelist.f -o uart_echo_sim || exit 1
sim_out=$(./obj_dir/uart_echo_sim 2>&1)
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -q "^STATUS: PASS$" && exit 0 || exit 1
